/* include/exe_settings.svh */
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// data path width
`define EXE_XLEN 32

// register index width, 32 architectural registers
`define EXE_REG_W 5

`endif

/* verilog/exe_pkg.sv */
package exe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9,
        ALU_LUI  = 4'd10 // passes operand 2
    } alu_op_t;

    typedef enum logic [3:0] {
        MD_NONE   = 4'd0,
        MD_MUL    = 4'd1,
        MD_MULH   = 4'd2,
        MD_MULHSU = 4'd3,
        MD_MULHU  = 4'd4,
        MD_DIV    = 4'd5,
        MD_DIVU   = 4'd6,
        MD_REM    = 4'd7,
        MD_REMU   = 4'd8
    } md_op_t;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_JAL  = 4'd1,
        BR_JALR = 4'd2,
        BR_BEQ  = 4'd3,
        BR_BNE  = 4'd4,
        BR_BLT  = 4'd5,
        BR_BGE  = 4'd6,
        BR_BLTU = 4'd7,
        BR_BGEU = 4'd8
    } br_op_t;

    // operand source select
    typedef enum logic [1:0] {
        SRC_REG = 2'd0,
        SRC_IMM = 2'd1,
        SRC_PC  = 2'd2
    } src_sel_t;

endpackage

/* verilog/exe_alu.sv */
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_alu (
    input  exe_pkg::alu_op_t      op,
    input  logic [`EXE_XLEN-1:0]  a,
    input  logic [`EXE_XLEN-1:0]  b,
    output logic [`EXE_XLEN-1:0]  y
);
    import exe_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0]; // low five bits only

    always_comb begin
        case (op)
            ALU_ADD: begin
                y = a + b;
            end
            ALU_SUB: begin
                y = a - b;
            end
            ALU_SLT: begin
                y = {{(`EXE_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            ALU_SLTU: begin
                y = {{(`EXE_XLEN-1){1'b0}}, (a < b)};
            end
            ALU_AND: begin
                y = a & b;
            end
            ALU_OR: begin
                y = a | b;
            end
            ALU_XOR: begin
                y = a ^ b;
            end
            ALU_SLL: begin
                y = a << shamt;
            end
            ALU_SRL: begin
                y = a >> shamt;
            end
            ALU_SRA: begin
                y = $unsigned($signed(a) >>> shamt);
            end
            ALU_LUI: begin
                y = b; // upper immediate already shifted by decode
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

/* verilog/exe_muldiv.sv */
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_muldiv (
    input  exe_pkg::md_op_t       op,
    input  logic [`EXE_XLEN-1:0]  a,
    input  logic [`EXE_XLEN-1:0]  b,
    output logic [`EXE_XLEN-1:0]  y
);
    import exe_pkg::*;

    localparam int XLEN = `EXE_XLEN;

    logic                   a_signed;
    logic                   b_signed;
    logic signed [XLEN:0]   a_ext; // one extra bit carries the sign choice
    logic signed [XLEN:0]   b_ext;
    logic signed [2*XLEN+1:0] prod;
    logic                   div_zero;
    logic                   div_ovf;

    // mulhsu treats only a as signed
    assign a_signed = (op == MD_MULH) || (op == MD_MULHSU);
    assign b_signed = (op == MD_MULH);
    assign a_ext    = {a_signed & a[XLEN-1], a};
    assign b_ext    = {b_signed & b[XLEN-1], b};
    assign prod     = a_ext * b_ext;

    assign div_zero = (b == '0);
    assign div_ovf  = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1); // most negative / -1

    always_comb begin
        case (op)
            MD_MUL:    y = prod[XLEN-1:0];
            MD_MULH,
            MD_MULHSU,
            MD_MULHU:  y = prod[2*XLEN-1:XLEN];
            MD_DIV: begin
                if (div_zero)     y = '1;
                else if (div_ovf) y = a;
                else              y = $unsigned($signed(a) / $signed(b));
            end
            MD_DIVU:   y = div_zero ? '1 : a / b;
            MD_REM: begin
                if (div_zero)     y = a;
                else if (div_ovf) y = '0;
                else              y = $unsigned($signed(a) % $signed(b));
            end
            MD_REMU:   y = div_zero ? a : a % b;
            default:   y = '0;
        endcase
    end

endmodule

/* verilog/exe_branch.sv */
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_branch (
    input  exe_pkg::br_op_t       op,
    input  logic [`EXE_XLEN-1:0]  a,
    input  logic [`EXE_XLEN-1:0]  b,
    output logic                  taken
);
    import exe_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a == b);
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (op)
            BR_JAL,
            BR_JALR: taken = 1'b1; // jumps always go
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = !lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

endmodule

/* verilog/exe_stage.sv */
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  exe_pkg::alu_op_t       alu_op,
    input  exe_pkg::md_op_t        md_op,
    input  exe_pkg::br_op_t        br_op,
    input  exe_pkg::src_sel_t      sel1,
    input  exe_pkg::src_sel_t      sel2,
    input  logic [`EXE_XLEN-1:0]   pc,
    input  logic [`EXE_XLEN-1:0]   imm,
    input  logic [`EXE_REG_W-1:0]  rs1_idx,
    input  logic [`EXE_REG_W-1:0]  rs2_idx,
    input  logic [`EXE_XLEN-1:0]   rs1_val,
    input  logic [`EXE_XLEN-1:0]   rs2_val,
    input  logic [`EXE_REG_W-1:0]  rd_idx,
    input  logic                   rd_en,
    input  logic                   fwd_en,
    input  logic [`EXE_REG_W-1:0]  fwd_idx,
    input  logic [`EXE_XLEN-1:0]   fwd_data,
    output logic                   stg_valid,
    input  logic                   stg_ready,
    output logic [`EXE_XLEN-1:0]   res_pc,
    output logic [`EXE_REG_W-1:0]  res_rd_idx,
    output logic                   res_rd_en,
    output logic [`EXE_XLEN-1:0]   res_wdata,
    output logic                   res_taken,
    output logic [`EXE_XLEN-1:0]   res_target
);
    import exe_pkg::*;

    logic [`EXE_XLEN-1:0] rs1_fwd;
    logic [`EXE_XLEN-1:0] rs2_fwd;
    logic [`EXE_XLEN-1:0] op1;
    logic [`EXE_XLEN-1:0] op2;
    logic [`EXE_XLEN-1:0] alu_y;
    logic [`EXE_XLEN-1:0] md_y;
    logic [`EXE_XLEN-1:0] wdata;
    logic [`EXE_XLEN-1:0] target;
    logic                 taken;
    logic                 is_jump;
    logic                 accept;
    logic                 valid_q;

    function automatic logic [`EXE_XLEN-1:0] pick_src(
        input src_sel_t             sel,
        input logic [`EXE_XLEN-1:0] reg_val,
        input logic [`EXE_XLEN-1:0] imm_val,
        input logic [`EXE_XLEN-1:0] pc_val
    );
        case (sel)
            SRC_IMM: return imm_val;
            SRC_PC:  return pc_val;
            default: return reg_val;
        endcase
    endfunction

    // bypass from memory stage, x0 never forwarded
    assign rs1_fwd = (fwd_en && fwd_idx == rs1_idx && rs1_idx != '0) ? fwd_data : rs1_val;
    assign rs2_fwd = (fwd_en && fwd_idx == rs2_idx && rs2_idx != '0) ? fwd_data : rs2_val;

    assign op1 = pick_src(sel1, rs1_fwd, imm, pc);
    assign op2 = pick_src(sel2, rs2_fwd, imm, pc);

    exe_alu i_alu (
        .op (alu_op),
        .a  (op1),
        .b  (op2),
        .y  (alu_y)
    );

    exe_muldiv i_muldiv (
        .op (md_op),
        .a  (op1),
        .b  (op2),
        .y  (md_y)
    );

    // compare uses register values, not the selected operands
    exe_branch i_branch (
        .op    (br_op),
        .a     (rs1_fwd),
        .b     (rs2_fwd),
        .taken (taken)
    );

    assign is_jump = (br_op == BR_JAL) || (br_op == BR_JALR);
    assign target  = (br_op == BR_JALR) ? {alu_y[`EXE_XLEN-1:1], 1'b0} : alu_y;

    always_comb begin
        if (is_jump)              wdata = pc + `EXE_XLEN'd4; // link address
        else if (md_op != MD_NONE) wdata = md_y;
        else                      wdata = alu_y;
    end

    assign in_ready = !valid_q || stg_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (stg_ready) begin
            valid_q <= 1'b0; // drained, nothing new
        end
    end

    // result record
    always_ff @(posedge clk) begin
        if (accept) begin
            res_pc     <= pc;
            res_rd_idx <= rd_idx;
            res_rd_en  <= rd_en;
            res_wdata  <= wdata;
            res_taken  <= taken;
            res_target <= target;
        end
    end

    assign stg_valid = valid_q;

endmodule

/* verilog/exe_result_queue.sv */
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_result_queue (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   wr_valid,
    output logic                   wr_ready,
    input  logic [`EXE_XLEN-1:0]   wr_pc,
    input  logic [`EXE_REG_W-1:0]  wr_rd_idx,
    input  logic                   wr_rd_en,
    input  logic [`EXE_XLEN-1:0]   wr_wdata,
    input  logic                   wr_taken,
    input  logic [`EXE_XLEN-1:0]   wr_target,
    output logic                   rd_valid,
    input  logic                   rd_ready,
    output logic [`EXE_XLEN-1:0]   rd_pc,
    output logic [`EXE_REG_W-1:0]  rd_rd_idx,
    output logic                   rd_rd_en,
    output logic [`EXE_XLEN-1:0]   rd_wdata,
    output logic                   rd_taken,
    output logic [`EXE_XLEN-1:0]   rd_target
);
    logic [`EXE_XLEN-1:0]  pc_mem     [2];
    logic [`EXE_REG_W-1:0] rd_idx_mem [2];
    logic                  rd_en_mem  [2];
    logic [`EXE_XLEN-1:0]  wdata_mem  [2];
    logic                  taken_mem  [2];
    logic [`EXE_XLEN-1:0]  target_mem [2];
    logic                  wr_ptr;
    logic                  rd_ptr;
    logic [1:0]            count;
    logic                  do_wr;
    logic                  do_rd;

    assign rd_valid = (count != 2'd0);
    assign wr_ready = (count != 2'd2) || rd_ready; // full still takes a write on a pop
    assign do_wr    = wr_valid && wr_ready;
    assign do_rd    = rd_valid && rd_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (do_wr) wr_ptr <= !wr_ptr;
            if (do_rd) rd_ptr <= !rd_ptr;
            count <= count + {1'b0, do_wr} - {1'b0, do_rd};
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            pc_mem[wr_ptr]     <= wr_pc;
            rd_idx_mem[wr_ptr] <= wr_rd_idx;
            rd_en_mem[wr_ptr]  <= wr_rd_en;
            wdata_mem[wr_ptr]  <= wr_wdata;
            taken_mem[wr_ptr]  <= wr_taken;
            target_mem[wr_ptr] <= wr_target;
        end
    end

    // head entry
    assign rd_pc     = pc_mem[rd_ptr];
    assign rd_rd_idx = rd_idx_mem[rd_ptr];
    assign rd_rd_en  = rd_en_mem[rd_ptr];
    assign rd_wdata  = wdata_mem[rd_ptr];
    assign rd_taken  = taken_mem[rd_ptr];
    assign rd_target = target_mem[rd_ptr];

endmodule

/* verilog/exe_top.sv */
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  exe_pkg::alu_op_t       alu_op,
    input  exe_pkg::md_op_t        md_op,
    input  exe_pkg::br_op_t        br_op,
    input  exe_pkg::src_sel_t      sel1,
    input  exe_pkg::src_sel_t      sel2,
    input  logic [`EXE_XLEN-1:0]   pc,
    input  logic [`EXE_XLEN-1:0]   imm,
    input  logic [`EXE_REG_W-1:0]  rs1_idx,
    input  logic [`EXE_REG_W-1:0]  rs2_idx,
    input  logic [`EXE_XLEN-1:0]   rs1_val,
    input  logic [`EXE_XLEN-1:0]   rs2_val,
    input  logic [`EXE_REG_W-1:0]  rd_idx,
    input  logic                   rd_en,
    input  logic                   fwd_en,
    input  logic [`EXE_REG_W-1:0]  fwd_idx,
    input  logic [`EXE_XLEN-1:0]   fwd_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [`EXE_XLEN-1:0]   out_pc,
    output logic [`EXE_REG_W-1:0]  out_rd_idx,
    output logic                   out_rd_en,
    output logic [`EXE_XLEN-1:0]   out_wdata,
    output logic                   out_taken,
    output logic [`EXE_XLEN-1:0]   out_target
);
    logic                  stg_valid;
    logic                  stg_ready;
    logic [`EXE_XLEN-1:0]  res_pc;
    logic [`EXE_REG_W-1:0] res_rd_idx;
    logic                  res_rd_en;
    logic [`EXE_XLEN-1:0]  res_wdata;
    logic                  res_taken;
    logic [`EXE_XLEN-1:0]  res_target;

    exe_stage i_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .alu_op     (alu_op),
        .md_op      (md_op),
        .br_op      (br_op),
        .sel1       (sel1),
        .sel2       (sel2),
        .pc         (pc),
        .imm        (imm),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .rd_idx     (rd_idx),
        .rd_en      (rd_en),
        .fwd_en     (fwd_en),
        .fwd_idx    (fwd_idx),
        .fwd_data   (fwd_data),
        .stg_valid  (stg_valid),
        .stg_ready  (stg_ready),
        .res_pc     (res_pc),
        .res_rd_idx (res_rd_idx),
        .res_rd_en  (res_rd_en),
        .res_wdata  (res_wdata),
        .res_taken  (res_taken),
        .res_target (res_target)
    );

    // decouples the stage from a stalling consumer
    exe_result_queue i_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_valid  (stg_valid),
        .wr_ready  (stg_ready),
        .wr_pc     (res_pc),
        .wr_rd_idx (res_rd_idx),
        .wr_rd_en  (res_rd_en),
        .wr_wdata  (res_wdata),
        .wr_taken  (res_taken),
        .wr_target (res_target),
        .rd_valid  (out_valid),
        .rd_ready  (out_ready),
        .rd_pc     (out_pc),
        .rd_rd_idx (out_rd_idx),
        .rd_rd_en  (out_rd_en),
        .rd_wdata  (out_wdata),
        .rd_taken  (out_taken),
        .rd_target (out_target)
    );

endmodule

/* tb/tb_exe_clkgen.sv */
`timescale 1ns/1ps

module tb_exe_clkgen (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

/* tb/tb_exe.sv */
`timescale 1ns/1ps
`include "exe_settings.svh"

module tb_exe;
    import exe_pkg::*;

    localparam int N_VEC       = 41;
    localparam int IDLE_LIMIT  = 200; // cycles without any handshake
    localparam int RST_LIMIT   = 20;
    localparam int DRAIN_CHECK = 4;

    logic                  clk;
    logic                  arst_n;
    logic                  in_valid;
    logic                  in_ready;
    alu_op_t               alu_op;
    md_op_t                md_op;
    br_op_t                br_op;
    src_sel_t              sel1;
    src_sel_t              sel2;
    logic [`EXE_XLEN-1:0]  pc;
    logic [`EXE_XLEN-1:0]  imm;
    logic [`EXE_REG_W-1:0] rs1_idx;
    logic [`EXE_REG_W-1:0] rs2_idx;
    logic [`EXE_XLEN-1:0]  rs1_val;
    logic [`EXE_XLEN-1:0]  rs2_val;
    logic [`EXE_REG_W-1:0] rd_idx;
    logic                  rd_en;
    logic                  fwd_en;
    logic [`EXE_REG_W-1:0] fwd_idx;
    logic [`EXE_XLEN-1:0]  fwd_data;
    logic                  out_valid;
    logic                  out_ready;
    logic [`EXE_XLEN-1:0]  out_pc;
    logic [`EXE_REG_W-1:0] out_rd_idx;
    logic                  out_rd_en;
    logic [`EXE_XLEN-1:0]  out_wdata;
    logic                  out_taken;
    logic [`EXE_XLEN-1:0]  out_target;

    logic [287:0] vec_mem [N_VEC]; // one line of testdata per entry
    int           exp_q [$];       // indices of accepted vectors
    logic [31:0]  rng;

    tb_exe_clkgen i_clkgen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    exe_top i_exe_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .alu_op     (alu_op),
        .md_op      (md_op),
        .br_op      (br_op),
        .sel1       (sel1),
        .sel2       (sel2),
        .pc         (pc),
        .imm        (imm),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .rd_idx     (rd_idx),
        .rd_en      (rd_en),
        .fwd_en     (fwd_en),
        .fwd_idx    (fwd_idx),
        .fwd_data   (fwd_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_pc     (out_pc),
        .out_rd_idx (out_rd_idx),
        .out_rd_en  (out_rd_en),
        .out_wdata  (out_wdata),
        .out_taken  (out_taken),
        .out_target (out_target)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_data(input string name, input logic [`EXE_XLEN-1:0] got,
                              input logic [`EXE_XLEN-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_idx(input string name, input logic [`EXE_REG_W-1:0] got,
                             input logic [`EXE_REG_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // vector line fields from the top bit down
    task automatic drive_vector(input int idx);
        logic [287:0] v;
        v = vec_mem[idx];
        alu_op   <= alu_op_t'(v[287:284]);
        md_op    <= md_op_t'(v[283:280]);
        br_op    <= br_op_t'(v[279:276]);
        sel1     <= src_sel_t'(v[273:272]);
        sel2     <= src_sel_t'(v[269:268]);
        pc       <= v[267:236];
        imm      <= v[235:204];
        rs1_idx  <= v[200:196];
        rs2_idx  <= v[192:188];
        rs1_val  <= v[187:156];
        rs2_val  <= v[155:124];
        rd_idx   <= v[120:116];
        rd_en    <= v[112];
        fwd_en   <= v[108];
        fwd_idx  <= v[104:100];
        fwd_data <= v[99:68];
    endtask

    task automatic compare_record(input int idx);
        logic [287:0] v;
        v = vec_mem[idx];
        check_data("out_pc", out_pc, v[267:236]);
        check_idx("out_rd_idx", out_rd_idx, v[120:116]);
        check_flag("out_rd_en", out_rd_en, v[112]);
        check_data("out_wdata", out_wdata, v[67:36]);
        check_flag("out_taken", out_taken, v[32]);
        check_data("out_target", out_target, v[31:0]);
    endtask

    initial begin
        int  n_acc;
        int  n_out;
        int  idle;
        int  wait_cnt;
        int  idx;
        bit  fire_in;
        bit  fire_out;

        in_valid  = 1'b0;
        out_ready = 1'b0;
        alu_op    = ALU_ADD;
        md_op     = MD_NONE;
        br_op     = BR_NONE;
        sel1      = SRC_REG;
        sel2      = SRC_REG;
        pc        = '0;
        imm       = '0;
        rs1_idx   = '0;
        rs2_idx   = '0;
        rs1_val   = '0;
        rs2_val   = '0;
        rd_idx    = '0;
        rd_en     = 1'b0;
        fwd_en    = 1'b0;
        fwd_idx   = '0;
        fwd_data  = '0;
        rng       = 32'h23a6;
        n_acc     = 0;
        n_out     = 0;
        idle      = 0;
        wait_cnt  = 0;

        $readmemh("tb/exe_testdata.hex", vec_mem);

        while (arst_n !== 1'b1) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > RST_LIMIT) begin
                abort_run("timeout: reset was never released");
            end
        end

        @(negedge clk);
        check_flag("in_ready", in_ready, 1'b1); // empty pipe after reset

        while (n_out < N_VEC) begin
            @(negedge clk); // inputs only move on the rising edge
            fire_in  = in_valid && in_ready;
            fire_out = out_valid && out_ready;
            if (n_acc == 0) begin
                check_flag("out_valid", out_valid, 1'b0);
            end
            if (fire_out) begin
                if (exp_q.size() == 0) begin
                    abort_run("output record appeared with no instruction in flight");
                end else begin
                    idx = exp_q.pop_front();
                    compare_record(idx);
                    n_out++;
                end
            end
            if (fire_in) begin
                exp_q.push_back(n_acc);
                n_acc++;
            end
            if (fire_in || fire_out) begin
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > IDLE_LIMIT) begin
                abort_run("timeout: no input or output handshake for too many cycles");
            end

            @(posedge clk);
            rng = xorshift32(rng);
            if (fire_in || !in_valid) begin
                if (n_acc < N_VEC && rng[1:0] != 2'b00) begin
                    drive_vector(n_acc);
                    in_valid <= 1'b1;
                end else begin
                    in_valid <= 1'b0; // gap
                end
            end
            rng = xorshift32(rng);
            out_ready <= rng[4]; // stall about half the time
        end

        // no stray or repeated record once all are out
        repeat (DRAIN_CHECK) begin
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b0);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

/* tb/exe_testdata.hex */
// cols: alu md br sel1 sel2 _ pc _ imm _ rs1i rs2i _ rs1v _ rs2v _ rdi rden fwden fwdi
// then: fwd_data _ exp_wdata _ exp_taken _ exp_target
00000_00001000_00000000_0102_00000005_00000007_031000_00000000_0000000c_0_0000000c
10000_00001004_00000000_0102_00000003_00000005_041000_00000000_fffffffe_0_fffffffe
20000_00001008_00000000_0102_ffffffff_00000001_051000_00000000_00000001_0_00000001
30000_0000100c_00000000_0102_ffffffff_00000001_061000_00000000_00000000_0_00000000
40000_00001010_00000000_0102_f0f0f0f0_0ff00ff0_071000_00000000_00f000f0_0_00f000f0
50000_00001014_00000000_0102_f0f0f0f0_0ff00ff0_081000_00000000_fff0fff0_0_fff0fff0
60000_00001018_00000000_0102_f0f0f0f0_0ff00ff0_091000_00000000_ff00ff00_0_ff00ff00
70001_0000101c_00000024_0100_12345678_00000000_0a1000_00000000_23456780_0_23456780
80001_00001020_00000004_0100_80000000_00000000_0b1000_00000000_08000000_0_08000000
90001_00001024_00000004_0100_80000000_00000000_0c1000_00000000_f8000000_0_f8000000
90000_00001028_00000000_0102_80000000_0000003f_0d1000_00000000_ffffffff_0_ffffffff
a0001_0000102c_12345000_0000_00000000_00000000_0e1000_00000000_12345000_0_12345000
00021_00001030_00002000_0000_00000000_00000000_0f1000_00000000_00003030_0_00003030
01000_00001034_00000000_0102_00000007_fffffffd_101000_00000000_ffffffeb_0_00000004
02000_00001038_00000000_0102_80000000_80000000_111000_00000000_40000000_0_00000000
03000_0000103c_00000000_0102_ffffffff_ffffffff_121000_00000000_ffffffff_0_fffffffe
04000_00001040_00000000_0102_ffffffff_ffffffff_131000_00000000_fffffffe_0_fffffffe
05000_00001044_00000000_0102_fffffff9_00000002_141000_00000000_fffffffd_0_fffffffb
06000_00001048_00000000_0102_fffffff9_00000002_151000_00000000_7ffffffc_0_fffffffb
07000_0000104c_00000000_0102_fffffff9_00000002_161000_00000000_ffffffff_0_fffffffb
08000_00001050_00000000_0102_fffffff9_00000002_171000_00000000_00000001_0_fffffffb
05000_00001054_00000000_0102_00001234_00000000_181000_00000000_ffffffff_0_00001234
07000_00001058_00000000_0102_00001234_00000000_191000_00000000_00001234_0_00001234
06000_0000105c_00000000_0102_00001234_00000000_1a1000_00000000_ffffffff_0_00001234
05000_00001060_00000000_0102_80000000_ffffffff_1b1000_00000000_80000000_0_7fffffff
07000_00001064_00000000_0102_80000000_ffffffff_1c1000_00000000_00000000_0_7fffffff
00321_00001068_00000010_0102_00000005_00000005_000000_00000000_00001078_1_00001078
00421_0000106c_00000010_0102_00000005_00000005_000000_00000000_0000107c_0_0000107c
00521_00001070_fffffff0_0102_ffffffff_00000001_000000_00000000_00001060_1_00001060
00721_00001074_fffffff0_0102_ffffffff_00000001_000000_00000000_00001064_0_00001064
00621_00001078_00000008_0102_ffffffff_00000001_000000_00000000_00001080_0_00001080
00821_0000107c_00000008_0102_ffffffff_00000001_000000_00000000_00001084_1_00001084
00121_00001080_00000100_0000_00000000_00000000_011000_00000000_00001084_1_00001180
00201_00001084_00000004_0500_00002001_00000000_021000_00000000_00001088_1_00002004
00000_00001088_00000000_0506_00000001_00000002_071105_00000100_00000102_0_00000102
00000_0000108c_00000000_0506_00000001_00000002_071106_00000200_00000201_0_00000201
00000_00001090_00000000_0006_00000001_00000002_071100_00000999_00000003_0_00000003
00000_00001094_00000000_0506_00000001_00000002_071107_00000999_00000003_0_00000003
00000_00001098_00000000_0505_00000001_00000002_071105_00000010_00000020_0_00000020
00000_0000109c_00000000_0506_00000001_00000002_071005_00000999_00000003_0_00000003
00321_000010a0_00000020_0506_00000001_00000100_000105_00000100_000010c0_1_000010c0

/* files.f */
+incdir+include
verilog/exe_pkg.sv
verilog/exe_alu.sv
verilog/exe_muldiv.sv
verilog/exe_branch.sv
verilog/exe_stage.sv
verilog/exe_result_queue.sv
verilog/exe_top.sv
tb/tb_exe_clkgen.sv
tb/tb_exe.sv

/* run.sh */
#!/bin/sh
# build with Verilator and run; exit status follows the simulation
verilator --binary --timing -f files.f --top-module tb_exe -o tb_exe_sim \
    && ./obj_dir/tb_exe_sim \
    || { echo "simulation failed"; exit 1; }
